/* rtl/l2_miss_defines.svh */
// Size macros for the L2 miss tracker: pending table, request queue, line index
`ifndef L2_MISS_DEFINES_SVH
`define L2_MISS_DEFINES_SVH

// Entries in the pending-miss table
// A miss can be pending anywhere between the miss stage and memory, so this
// has to cover the request queue plus the two pipeline stages in front of it
`define L2_PENDING_ENTRIES 8

// Depth of the system memory request queue
`define L2_SMI_DEPTH 4

// Bits in a cache line index, which is the byte address without the line offset
`define L2_LINE_INDEX_WIDTH 26

`endif

/* rtl/l2_miss_pkg.sv */
// Package with the line index, pending index and count typedefs and the request struct
`default_nettype none

`include "l2_miss_defines.svh"

package l2_miss_pkg;

	// Address of one cache line as seen by the L2
	typedef logic [`L2_LINE_INDEX_WIDTH - 1:0] cache_line_index_t;

	// Selects one entry of the pending-miss table
	typedef logic [$clog2(`L2_PENDING_ENTRIES) - 1:0] pending_idx_t;

	// Occupancy of the request queue, from empty up to and including full
	typedef logic [$clog2(`L2_SMI_DEPTH + 1) - 1:0] smi_count_t;

	// One request as it leaves the miss stage register
	// Miss and fill are only ever set together with valid
	typedef struct packed
	{
		logic valid;
		logic miss;
		logic fill;
		cache_line_index_t addr;
	} l2_request_t;

endpackage

`default_nettype wire

/* rtl/l2_request_stage.sv */
// L2 miss stage register that turns the incoming request strobes into one request struct
`default_nettype none

module l2_request_stage
	(input wire logic clk,
	input wire logic reset,
	input wire logic request_valid,
	input wire l2_miss_pkg::cache_line_index_t request_addr,
	input wire logic request_miss,
	input wire logic request_fill,
	output l2_miss_pkg::l2_request_t stage_request);

	logic valid_q;
	logic miss_q;
	logic fill_q;
	l2_miss_pkg::cache_line_index_t addr_q;

	// Control bits of the stage
	// Flags are masked with valid so that an idle cycle never carries a stale
	// miss or fill into the pending-miss lookup
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_q <= 1'b0;
			miss_q <= 1'b0;
			fill_q <= 1'b0;
		end
		else
		begin
			valid_q <= request_valid;
			miss_q <= request_valid && request_miss;
			fill_q <= request_valid && request_fill;
		end
	end

	// Line address is payload and is only captured with a request
	always_ff @(posedge clk)
	begin
		if (request_valid)
			addr_q <= request_addr;
	end

	// Present the stage contents as one struct to the pending-miss CAM
	assign stage_request = '{
		valid: valid_q,
		miss: miss_q,
		fill: fill_q,
		addr: addr_q
	};

endmodule

`default_nettype wire

/* rtl/cam.sv */
// Generic content-addressable memory with single-cycle lookup and one update port
`default_nettype none

module cam
	#(parameter NUM_ENTRIES = 8,
	parameter KEY_WIDTH = 32)
	(input wire logic clk,
	input wire logic reset,
	input wire logic [KEY_WIDTH - 1:0] lookup_key,
	output logic lookup_hit,
	output logic [$clog2(NUM_ENTRIES) - 1:0] lookup_idx,
	input wire logic update_en,
	input wire logic [$clog2(NUM_ENTRIES) - 1:0] update_idx,
	input wire logic [KEY_WIDTH - 1:0] update_key,
	input wire logic update_valid);

	localparam int IDX_WIDTH = $clog2(NUM_ENTRIES);

	logic [KEY_WIDTH - 1:0] entry_key[NUM_ENTRIES];
	logic [NUM_ENTRIES - 1:0] entry_valid;
	logic [NUM_ENTRIES - 1:0] match_oh;

	// Compare the key against every entry at once
	// Only entries holding a live key can match
	always_comb
	begin
		for (int i = 0; i < NUM_ENTRIES; i++)
			match_oh[i] = entry_valid[i] && (entry_key[i] == lookup_key);
	end

	// The owner never writes the same key into two valid entries, so at most
	// one match bit is set and OR-ing the indexes of set bits gives the entry
	always_comb
	begin
		lookup_idx = '0;
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			if (match_oh[i])
				lookup_idx = lookup_idx | IDX_WIDTH'(i);
		end
	end

	assign lookup_hit = |match_oh;

	// Valid bits decide which entries take part in the lookup
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			entry_valid <= '0;
		else if (update_en)
			entry_valid[update_idx] <= update_valid;
	end

	// Keys are storage and are meaningless until their valid bit is set
	always_ff @(posedge clk)
	begin
		if (update_en)
			entry_key[update_idx] <= update_key;
	end

endmodule

`default_nettype wire

/* rtl/l2_pending_miss_cam.sv */
// Pending-miss table that flags duplicate requests and decides which misses go to memory
`default_nettype none

`include "l2_miss_defines.svh"

module l2_pending_miss_cam
	(input wire logic clk,
	input wire logic reset,
	input wire l2_miss_pkg::l2_request_t stage_request,
	output logic duplicate_request,
	output logic enqueue_valid,
	output l2_miss_pkg::cache_line_index_t enqueue_addr);

	localparam int NUM_ENTRIES = `L2_PENDING_ENTRIES;

	logic cam_hit;
	l2_miss_pkg::pending_idx_t cam_hit_idx;
	// One bit per table entry, set while that entry holds no pending line
	logic [NUM_ENTRIES - 1:0] free_entries;
	logic [NUM_ENTRIES - 1:0] next_free_oh;
	l2_miss_pkg::pending_idx_t next_free_idx;
	logic table_full;
	logic request_hit;
	logic need_entry;
	logic alloc_entry;
	logic release_entry;

	// Line lookup runs on the registered request in the same cycle
	cam #(.NUM_ENTRIES(NUM_ENTRIES),
		.KEY_WIDTH($bits(l2_miss_pkg::cache_line_index_t))) pending_lines(
		.clk(clk),
		.reset(reset),
		.lookup_key(stage_request.addr),
		.lookup_hit(cam_hit),
		.lookup_idx(cam_hit_idx),
		.update_en(alloc_entry || release_entry),
		.update_idx(request_hit ? cam_hit_idx : next_free_idx),
		.update_key(stage_request.addr),
		.update_valid(alloc_entry));

	// Isolate the lowest set bit of the free mask
	assign next_free_oh = free_entries & ~(free_entries - 1'b1);

	// Turn the isolated free bit into an entry number
	always_comb
	begin
		next_free_idx = '0;
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			if (next_free_oh[i])
				next_free_idx = next_free_idx | l2_miss_pkg::pending_idx_t'(i);
		end
	end

	assign table_full = (free_entries == '0);

	// A hit means some earlier transaction already owns this line
	assign request_hit = stage_request.valid && cam_hit;

	// Returning fill data ends the pending transaction for its line
	assign release_entry = request_hit && stage_request.fill;

	// First miss to a line needs a table entry and a memory read
	assign need_entry = stage_request.valid && stage_request.miss && !cam_hit;

	// A first miss takes an entry only while one is free
	// With the table full the miss gets neither an entry nor a memory read
	assign alloc_entry = need_entry && !table_full;

	// Outputs come off the stage register and the lookup, so the flag is valid
	// in the cycle after the strobe and the push lands on the next edge
	assign duplicate_request = request_hit;
	assign enqueue_valid = alloc_entry;
	assign enqueue_addr = stage_request.addr;

	// Free mask follows the CAM valid bits
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			free_entries <= '1;
		else if (release_entry)
			free_entries[cam_hit_idx] <= 1'b1;
		else if (alloc_entry)
			free_entries[next_free_idx] <= 1'b0;
	end

endmodule

`default_nettype wire

/* rtl/smi_request_queue.sv */
// System memory request queue holding line indexes that wait for a memory read
`default_nettype none

`include "l2_miss_defines.svh"

module smi_request_queue
	(input wire logic clk,
	input wire logic reset,
	input wire logic enqueue_valid,
	input wire l2_miss_pkg::cache_line_index_t enqueue_addr,
	input wire logic mem_read_ack,
	output logic mem_read_valid,
	output l2_miss_pkg::cache_line_index_t mem_read_addr,
	output logic smi_full);

	localparam int DEPTH = `L2_SMI_DEPTH;
	localparam int PTR_WIDTH = $clog2(DEPTH);
	localparam logic [PTR_WIDTH - 1:0] LAST_SLOT = PTR_WIDTH'(DEPTH - 1);
	localparam l2_miss_pkg::smi_count_t FULL_COUNT = l2_miss_pkg::smi_count_t'(DEPTH);

	l2_miss_pkg::cache_line_index_t slots[DEPTH];
	logic [PTR_WIDTH - 1:0] write_ptr;
	logic [PTR_WIDTH - 1:0] read_ptr;
	l2_miss_pkg::smi_count_t count;
	logic push;
	logic pop;

	// There is no stall path back to the miss stage
	// A push that finds the queue full is simply not taken
	assign push = enqueue_valid && !smi_full;

	// Memory only acknowledges a read that is being shown
	assign pop = mem_read_ack && mem_read_valid;

	// Levels seen by memory and by the rest of the cache
	assign mem_read_valid = (count != '0);
	assign smi_full = (count == FULL_COUNT);
	assign mem_read_addr = slots[read_ptr];

	// Pointers wrap explicitly so the depth need not be a power of two
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			write_ptr <= '0;
			read_ptr <= '0;
		end
		else
		begin
			if (push)
				write_ptr <= (write_ptr == LAST_SLOT) ? '0 : write_ptr + 1'b1;

			if (pop)
				read_ptr <= (read_ptr == LAST_SLOT) ? '0 : read_ptr + 1'b1;
		end
	end

	// Push and pop together leave the count alone
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (push && !pop)
			count <= count + 1'b1;
		else if (pop && !push)
			count <= count - 1'b1;
	end

	// Slot contents only matter between push and pop
	always_ff @(posedge clk)
	begin
		if (push)
			slots[write_ptr] <= enqueue_addr;
	end

endmodule

`default_nettype wire

/* rtl/l2_miss_tracker.sv */
// Top level of the L2 miss tracker: miss stage, pending-miss CAM and memory request queue
`default_nettype none

module l2_miss_tracker
	(input wire logic clk,
	input wire logic reset,
	input wire logic request_valid,
	input wire l2_miss_pkg::cache_line_index_t request_addr,
	input wire logic request_miss,
	input wire logic request_fill,
	input wire logic mem_read_ack,
	output logic mem_read_valid,
	output l2_miss_pkg::cache_line_index_t mem_read_addr,
	output logic duplicate_request,
	output logic smi_full);

	// Request as registered by the miss stage
	l2_miss_pkg::l2_request_t stage_request;

	// First misses on their way into the request queue
	logic enqueue_valid;
	l2_miss_pkg::cache_line_index_t enqueue_addr;

	// Strobes in, one registered request out
	l2_request_stage request_stage(
		.clk(clk),
		.reset(reset),
		.request_valid(request_valid),
		.request_addr(request_addr),
		.request_miss(request_miss),
		.request_fill(request_fill),
		.stage_request(stage_request));

	// Filters out loads for lines that already have one in flight
	l2_pending_miss_cam pending_miss_cam(
		.clk(clk),
		.reset(reset),
		.stage_request(stage_request),
		.duplicate_request(duplicate_request),
		.enqueue_valid(enqueue_valid),
		.enqueue_addr(enqueue_addr));

	// Hands reads to memory one at a time, in order of arrival
	smi_request_queue request_queue(
		.clk(clk),
		.reset(reset),
		.enqueue_valid(enqueue_valid),
		.enqueue_addr(enqueue_addr),
		.mem_read_ack(mem_read_ack),
		.mem_read_valid(mem_read_valid),
		.mem_read_addr(mem_read_addr),
		.smi_full(smi_full));

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Free-running testbench clock source
`default_nettype none

module tb_clock_gen
	#(parameter int PERIOD = 40)
	(output logic clk);

	// Start low so the first rising edge comes half a period into the run
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* tb/l2_miss_tracker_chk.sv */
// Bound checker for request queue and pending-table invariants of the L2 miss tracker
`default_nettype none

module l2_miss_tracker_chk
	(input wire logic clk,
	input wire logic reset,
	input wire logic enqueue_valid,
	input wire logic smi_full,
	input wire logic need_entry,
	input wire logic table_full,
	input wire logic mem_read_valid,
	input wire logic mem_read_ack);

	// Number of assertion failures, read by the testbench at the end of the run
	int failure_count = 0;

	// Reads the queue should hold, counted from the pushes and pops at its ports
	l2_miss_pkg::smi_count_t held_reads;
	logic push_seen;
	logic pop_seen;

	// A push is taken unless the queue is full
	assign push_seen = enqueue_valid && !smi_full;

	// An acknowledge only removes a read that was counted in
	assign pop_seen = mem_read_ack && (held_reads != '0);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			held_reads <= '0;
		else if (push_seen && !pop_seen)
			held_reads <= held_reads + 1'b1;
		else if (pop_seen && !push_seen)
			held_reads <= held_reads - 1'b1;
	end

	// A first miss must always find room in the request queue
	push_needs_room: assert property (@(posedge clk) disable iff (reset)
		enqueue_valid |-> !smi_full)
	else
	begin
		failure_count++;
		$error("Push to the memory request queue while it is full");
	end

	// The table is sized so a first miss always gets an entry
	entry_available: assert property (@(posedge clk) disable iff (reset)
		need_entry |-> !table_full)
	else
	begin
		failure_count++;
		$error("First miss found the pending table full");
	end

	// A read is only shown to memory while the queue holds something
	read_valid_has_data: assert property (@(posedge clk) disable iff (reset)
		mem_read_valid |-> (held_reads != '0))
	else
	begin
		failure_count++;
		$error("Memory read shown with an empty request queue");
	end

endmodule

`default_nettype wire

/* tb/l2_miss_tracker_tb.sv */
// Directed and random testbench for the L2 miss tracker with a pending-line reference model
`default_nettype none

`include "l2_miss_defines.svh"

module l2_miss_tracker_tb;

	localparam int SMI_DEPTH = `L2_SMI_DEPTH;
	localparam int PENDING_ENTRIES = `L2_PENDING_ENTRIES;
	localparam int DRAIN_LIMIT = 50;
	localparam int RANDOM_CYCLES = 300;
	localparam int LINE_SET = 6;

	logic clk;
	logic reset;
	logic request_valid;
	l2_miss_pkg::cache_line_index_t request_addr;
	logic request_miss;
	logic request_fill;
	logic mem_read_ack;
	logic mem_read_valid;
	l2_miss_pkg::cache_line_index_t mem_read_addr;
	logic duplicate_request;
	logic smi_full;

	// Reference model: lines with a load in flight and reads memory should see
	l2_miss_pkg::cache_line_index_t pending_lines[$];
	l2_miss_pkg::cache_line_index_t expected_reads[$];
	// Duplicate flag expected at the next falling edge
	logic expected_dup;
	// First miss sitting in the miss stage, pushed at the coming rising edge
	logic stage_push;
	l2_miss_pkg::cache_line_index_t stage_push_addr;

	int error_count;
	string test_name;

	tb_clock_gen #(.PERIOD(40)) clock_gen(.clk(clk));

	l2_miss_tracker uut(
		.clk(clk),
		.reset(reset),
		.request_valid(request_valid),
		.request_addr(request_addr),
		.request_miss(request_miss),
		.request_fill(request_fill),
		.mem_read_ack(mem_read_ack),
		.mem_read_valid(mem_read_valid),
		.mem_read_addr(mem_read_addr),
		.duplicate_request(duplicate_request),
		.smi_full(smi_full));

	bind l2_miss_tracker l2_miss_tracker_chk checker_inst(
		.clk(clk),
		.reset(reset),
		.enqueue_valid(enqueue_valid),
		.smi_full(smi_full),
		.need_entry(pending_miss_cam.need_entry),
		.table_full(pending_miss_cam.table_full),
		.mem_read_valid(mem_read_valid),
		.mem_read_ack(mem_read_ack));

	// Compare one observed value with its expected value
	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
	begin
		if (actual !== expected)
		begin
			$display("Error %s: %s expected %h actual %h", test_name, what, expected, actual);
			error_count++;
		end
	end
	endtask

	function automatic bit is_pending(input l2_miss_pkg::cache_line_index_t addr);
		bit found;
		found = 1'b0;
		foreach (pending_lines[i])
		begin
			if (pending_lines[i] == addr)
				found = 1'b1;
		end
		return found;
	endfunction

	function automatic void drop_pending(input l2_miss_pkg::cache_line_index_t addr);
		int slot;
		slot = -1;
		foreach (pending_lines[i])
		begin
			if (pending_lines[i] == addr)
				slot = i;
		end
		if (slot >= 0)
			pending_lines.delete(slot);
	endfunction

	// One clock cycle, entered and left at a falling edge
	// Outputs are checked first, then inputs are driven and the model advanced
	task automatic apply_cycle(input logic valid, input l2_miss_pkg::cache_line_index_t addr,
		input logic miss, input logic fill, input logic ack);
		int occupancy;
		bit hit;
	begin
		occupancy = expected_reads.size();
		compare("duplicate_request", expected_dup, duplicate_request);
		compare("mem_read_valid", occupancy != 0, mem_read_valid);
		compare("smi_full", occupancy == SMI_DEPTH, smi_full);
		if (occupancy != 0)
			compare("mem_read_addr", expected_reads[0], mem_read_addr);

		request_valid = valid;
		request_addr = addr;
		request_miss = miss;
		request_fill = fill;
		mem_read_ack = ack;

		// Pop and push share the next edge, a push only sees the old count
		if (ack && occupancy != 0)
			void'(expected_reads.pop_front());
		if (stage_push && occupancy < SMI_DEPTH)
			expected_reads.push_back(stage_push_addr);

		hit = valid && is_pending(addr);
		expected_dup = hit;
		stage_push = 1'b0;
		if (hit && fill)
			drop_pending(addr);
		else if (!hit && valid && miss && pending_lines.size() < PENDING_ENTRIES)
		begin
			pending_lines.push_back(addr);
			stage_push = 1'b1;
			stage_push_addr = addr;
		end

		@(negedge clk);
	end
	endtask

	task automatic idle_cycles(input int count);
	begin
		repeat (count)
			apply_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
	end
	endtask

	// Acknowledge reads until memory sees none left
	task automatic drain_reads();
		int guard;
	begin
		guard = 0;
		while ((mem_read_valid || stage_push) && guard < DRAIN_LIMIT)
		begin
			apply_cycle(1'b0, '0, 1'b0, 1'b0, 1'b1);
			guard++;
		end
		if (mem_read_valid)
		begin
			$display("Timeout in %s while draining memory reads", test_name);
			error_count++;
		end
		idle_cycles(1);
	end
	endtask

	// Return fill data for every line the model still holds as pending
	task automatic release_all_lines();
		l2_miss_pkg::cache_line_index_t snapshot[$];
	begin
		snapshot = pending_lines;
		foreach (snapshot[i])
			apply_cycle(1'b1, snapshot[i], 1'b0, 1'b1, 1'b0);
		idle_cycles(2);
		compare("pending lines left", 0, pending_lines.size());
	end
	endtask

	task automatic check_reset_state();
	begin
		test_name = "reset_state";
		compare("mem_read_valid", 0, mem_read_valid);
		compare("duplicate_request", 0, duplicate_request);
		compare("smi_full", 0, smi_full);
		idle_cycles(2);
	end
	endtask

	task automatic first_miss_reaches_memory();
	begin
		test_name = "first_miss";
		apply_cycle(1'b1, 26'h0000123, 1'b1, 1'b0, 1'b0);
		compare("duplicate_request", 0, duplicate_request);
		idle_cycles(1);
		// Two cycles after the strobe the line is at the head of the queue
		compare("mem_read_valid", 1, mem_read_valid);
		compare("mem_read_addr", 26'h0000123, mem_read_addr);
		drain_reads();
		release_all_lines();
	end
	endtask

	task automatic repeated_miss_is_filtered();
	begin
		test_name = "duplicate_miss";
		apply_cycle(1'b1, 26'h0000456, 1'b1, 1'b0, 1'b0);
		apply_cycle(1'b1, 26'h0000456, 1'b1, 1'b0, 1'b0);
		compare("duplicate_request", 1, duplicate_request);
		drain_reads();
		// No second read may follow the first one
		idle_cycles(4);
		compare("mem_read_valid", 0, mem_read_valid);
		release_all_lines();
	end
	endtask

	task automatic fill_releases_line();
	begin
		test_name = "fill_release";
		apply_cycle(1'b1, 26'h0000789, 1'b1, 1'b0, 1'b0);
		drain_reads();
		apply_cycle(1'b1, 26'h0000789, 1'b0, 1'b1, 1'b0);
		compare("duplicate_request", 1, duplicate_request);
		// Line is free again, so a new miss goes back to memory
		apply_cycle(1'b1, 26'h0000789, 1'b1, 1'b0, 1'b0);
		compare("duplicate_request", 0, duplicate_request);
		idle_cycles(1);
		compare("mem_read_addr", 26'h0000789, mem_read_addr);
		drain_reads();
		// Fill for a line nobody asked for leaves everything alone
		apply_cycle(1'b1, 26'h0000abc, 1'b0, 1'b1, 1'b0);
		compare("duplicate_request", 0, duplicate_request);
		idle_cycles(3);
		release_all_lines();
	end
	endtask

	task automatic reads_keep_order();
	begin
		test_name = "read_order";
		for (int i = 0; i < SMI_DEPTH; i++)
			apply_cycle(1'b1, 26'h0001000 + 26'(i), 1'b1, 1'b0, 1'b0);
		idle_cycles(2);
		compare("smi_full", 1, smi_full);
		drain_reads();
		release_all_lines();
	end
	endtask

	task automatic random_traffic();
		l2_miss_pkg::cache_line_index_t addr;
		int kind;
		logic miss;
		logic fill;
		logic ack;
	begin
		test_name = "random_mix";
		for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++)
		begin
			addr = 26'h0002000 + 26'($urandom_range(0, LINE_SET - 1));
			kind = $urandom_range(0, 3);
			ack = 1'($urandom_range(0, 1));
			miss = (kind == 1);
			fill = (kind == 2);
			// A first miss only goes out when the queue is sure to have room
			if (miss && !is_pending(addr) && expected_reads.size() + int'(stage_push) >= SMI_DEPTH)
				miss = 1'b0;
			apply_cycle(kind != 0, addr, miss, fill, ack);
		end
		drain_reads();
		release_all_lines();
	end
	endtask

	initial
	begin
		void'($urandom(67));
		error_count = 0;
		test_name = "init";
		expected_dup = 1'b0;
		stage_push = 1'b0;
		stage_push_addr = '0;
		request_valid = 1'b0;
		request_addr = '0;
		request_miss = 1'b0;
		request_fill = 1'b0;
		mem_read_ack = 1'b0;
		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		check_reset_state();
		first_miss_reaches_memory();
		repeated_miss_is_filtered();
		fill_releases_line();
		reads_keep_order();
		random_traffic();

		$display("Errors: %0d test checks, %0d assertions", error_count,
			uut.checker_inst.failure_count);
		if (error_count == 0 && uut.checker_inst.failure_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/l2_miss_pkg.sv
rtl/l2_request_stage.sv
rtl/cam.sv
rtl/l2_pending_miss_cam.sv
rtl/smi_request_queue.sv
rtl/l2_miss_tracker.sv
tb/tb_clock_gen.sv
tb/l2_miss_tracker_chk.sv
tb/l2_miss_tracker_tb.sv
